// File: character_sprites.sv
/*
 Fixed character sprites.
 Draws Pac-Man with a wedge mouth and a row of five ghosts with eyes and
 a stepped hem. Purely combinational from the raster position; Pac-Man
 is drawn over the ghosts.
*/
`timescale 1ns/1ps
`default_nettype none

module character_sprites
    import video_stream_pkg::*;
    import overlay_pkg::*;
(
    input  wire raster_pos_t pos_i,
    output layer_px_t        layer_o
);

`include "snow_overlay_consts.svh"

    localparam int   GHOST_XS  [`NUM_GHOSTS] = '{`GHOST_X0, `GHOST_X1, `GHOST_X2,
                                                 `GHOST_X3, `GHOST_X4};
    localparam rgb_t GHOST_COLS[`NUM_GHOSTS] = '{`COL_GHOST0, `COL_GHOST1, `COL_GHOST2,
                                                 `COL_GHOST3, `COL_GHOST4};

    layer_px_t   ghost_l[`NUM_GHOSTS];  // Per ghost
    layer_px_t   pac;
    layer_px_t   ghost;                 // Winning ghost
    layer_kind_e src;

    // Disc minus a wedge opening to the right
    function automatic layer_px_t pacman_px(input raster_pos_t p);
        logic signed [12:0] rx;
        logic signed [12:0] ry;
        logic signed [12:0] ay;
        logic signed [26:0] d2;
        rx = 13'(p.x) - 13'(`PAC_X);
        ry = 13'(p.y) - 13'(`PAC_Y);
        ay = (ry < 0) ? -ry : ry;
        d2 = rx * rx + ry * ry;
        pacman_px.rgb = `COL_PACMAN;
        pacman_px.hit = (d2 < `PAC_R2) &&
                        !((rx > 0) && (ay * 64 < rx * `PAC_MOUTH));  // Mouth cut
    endfunction

    function automatic layer_px_t ghost_px(input raster_pos_t p, input int gx, input rgb_t col);
        logic signed [12:0] rx;
        logic signed [12:0] ry;
        logic signed [12:0] ax;
        logic signed [12:0] ay;
        logic signed [26:0] d2;
        rx = 13'(p.x) - 13'(gx);
        ry = 13'(p.y) - 13'(`GHOST_Y);
        ax = (rx < 0) ? -rx : rx;
        ay = (ry < 0) ? -ry : ry;
        d2 = ax * ax + (ry + 13'sd5) * (ry + 13'sd5);
        ghost_px = '0;
        if (ax <= `GHOST_HALF_W && ay <= `GHOST_HALF_H) begin
            if (ry < -5) begin
                ghost_px.hit = (d2 < `GHOST_R2);     // Rounded top
            end else if (ry < 20) begin
                ghost_px.hit = 1'b1;                 // Body band
            end else begin                           // Stepped hem, five teeth
                ghost_px.hit = (rx >= -20 && rx < -12 && ry < 22) ||
                               (rx >= -12 && rx <  -4 && ry < 24) ||
                               (rx >=  -4 && rx <   4 && ry < 25) ||
                               (rx >=   4 && rx <  12 && ry < 24) ||
                               (rx >=  12 && rx <  20 && ry < 22);
            end
            ghost_px.rgb = col;
            if (ax >= 6 && ax <= 12 && ry >= -10 && ry <= -4) begin
                ghost_px.rgb = `COL_EYE;
            end
            if (ax >= 8 && ax <= 10 && ry >= -8 && ry <= -6) begin
                ghost_px.rgb = `COL_BLACK;           // Pupil, still a hit
            end
        end
    endfunction

    for (genvar g = 0; g < `NUM_GHOSTS; g++) begin : g_ghost
        assign ghost_l[g] = ghost_px(pos_i, GHOST_XS[g], GHOST_COLS[g]);
    end

    assign pac = pacman_px(pos_i);

    always_comb begin
        ghost = '0;
        for (int g = 0; g < `NUM_GHOSTS; g++) begin
            if (ghost_l[g].hit) ghost = ghost_l[g];  // Later ghost on top
        end

        src = NONE;
        if (ghost.hit) src = GHOST;
        if (pac.hit)   src = PACMAN;                 // Pac-Man over ghosts

        case (src)
            PACMAN:  layer_o = pac;
            GHOST:   layer_o = ghost;
            default: layer_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: layer_compositor.sv
/*
 Layer compositor and output register.
 Priority is flakes, then characters, then a black background.
 Colour and sync leave one enabled cycle after the pixel is seen.
*/
`timescale 1ns/1ps
`default_nettype none

module layer_compositor
    import video_stream_pkg::*;
    import overlay_pkg::*;
(
    input  wire logic      clk_i,
    input  wire logic      rst_i,
    input  wire logic      cen_i,
    input  wire sync_t     sync_i,
    input  wire layer_px_t char_i,
    input  wire layer_px_t flake_i,
    output rgb_t           rgb_o,
    output sync_t          sync_o
);

`include "snow_overlay_consts.svh"

    layer_kind_e win;     // Top layer at this pixel
    rgb_t        rgb_d;
    rgb_t        rgb_q;
    sync_t       sync_q;

    always_comb begin
        win = NONE;
        if (char_i.hit)  win = PACMAN;   // Character layer, Pac-Man or ghost
        if (flake_i.hit) win = FLAKE;    // Snow falls in front

        case (win)
            FLAKE:          rgb_d = flake_i.rgb;
            PACMAN, GHOST:  rgb_d = char_i.rgb;
            default:        rgb_d = `COL_BLACK;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rgb_q  <= '0;
            sync_q <= '0;
        end else if (cen_i) begin
            rgb_q  <= rgb_d;
            sync_q <= sync_i;            // Same delay as the colour
        end
    end

    assign rgb_o  = rgb_q;
    assign sync_o = sync_q;

endmodule

`default_nettype wire

// File: overlay_pkg.sv
/*
 Types of the drawing layers that sit over the video stream.
 A layer pixel carries its own hit flag, so black can still be drawn.
 Imported by the drawing modules and the compositor.
*/
`default_nettype none

package overlay_pkg;

    import video_stream_pkg::*;

    // One layer's vote for the current pixel
    typedef struct packed {
        logic hit;    // Clear means transparent
        rgb_t rgb;
    } layer_px_t;

    // Source names for priority decisions
    typedef enum logic [1:0] {
        FLAKE  = 2'd0,
        PACMAN = 2'd1,
        GHOST  = 2'd2,
        NONE   = 2'd3
    } layer_kind_e;

    // Animated snowflake state
    typedef struct packed {
        coord_t     x;
        coord_t     y;
        logic [3:0] speed;  // Pixels per frame, 1 to 8 after reset
    } flake_t;

endpackage

`default_nettype wire

// File: raster_position.sv
/*
 Raster position tracker.
 Recovers x and y from the blanking flags of the pixel stream and flags
 the first active line of each frame. Advances only on enabled cycles.
*/
`timescale 1ns/1ps
`default_nettype none

module raster_position
    import video_stream_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        rst_i,
    input  wire logic        cen_i,          // Pixel enable
    input  wire blank_t      blank_i,
    output raster_pos_t      pos_o,
    output logic             frame_start_o   // Vblank falling cycle
);

    logic   hblank_q;   // Previous hblank
    logic   vblank_q;   // Previous vblank
    coord_t x_q;
    coord_t y_q;

    logic   h_fall;     // Leaving hblank, line starts
    logic   h_rise;     // Entering hblank, line ends
    logic   v_fall;     // Leaving vblank, frame starts

    assign h_fall = hblank_q & ~blank_i.hblank;
    assign h_rise = ~hblank_q & blank_i.hblank;
    assign v_fall = vblank_q & ~blank_i.vblank;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            hblank_q <= 1'b0;
            vblank_q <= 1'b0;
            x_q      <= '0;
            y_q      <= '0;
        end else if (cen_i) begin
            hblank_q <= blank_i.hblank;
            vblank_q <= blank_i.vblank;

            if (h_fall) begin
                x_q <= '0;                  // First active pixel of the line
            end else if (!blank_i.hblank) begin
                x_q <= x_q + 11'd1;
            end

            // Frame start wins over a line end in the same cycle
            if (v_fall) begin
                y_q <= '0;
            end else if (h_rise) begin
                y_q <= y_q + 11'd1;
            end
        end
    end

    assign pos_o.x       = x_q;
    assign pos_o.y       = y_q;
    assign frame_start_o = v_fall;  // Consumer qualifies with cen_i

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build the snow overlay testbench with Verilator and run it.
# Exit status is 0 only when the log holds the pass message.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_snow_overlay \
    -f snow_overlay.f \
    --Mdir obj_dir -o sim_snow_overlay

./obj_dir/sim_snow_overlay 2>&1 | tee sim.log

if grep -qF '*** TEST PASSED ***' sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

// File: snow_overlay.f
+incdir+.
video_stream_pkg.sv
overlay_pkg.sv
raster_position.sv
snowflake_field.sv
character_sprites.sv
layer_compositor.sv
snow_overlay_top.sv
snow_overlay_props.sv
tb_snow_overlay.sv

// File: snow_overlay_consts.svh
/*
 Screen, sprite and colour constants for the snow overlay stage.
 Included by every RTL file that draws or composes a layer.
 Geometry in pixels, colours as 24-bit RGB.
*/
`ifndef SNOW_OVERLAY_CONSTS_SVH
`define SNOW_OVERLAY_CONSTS_SVH

// Active 1080p raster
`define SCREEN_W         1920
`define SCREEN_H         1080

// Snowflake field
`define NUM_FLAKES       12
`define FLAKE_HALF       8      // Half-size of a flake
`define FLAKE_WRAP_STEP  137    // X advance when a flake wraps to the top
`define FLAKE_X_SPACING  160    // Reset spread across the screen
`define FLAKE_Y_SPACING  90     // Reset stagger down the screen

// Pac-Man, fixed below the ghost row
`define PAC_X            960
`define PAC_Y            250
`define PAC_R2           900    // Radius 30, squared
`define PAC_MOUTH        45     // Mouth slope in 1/64 units

// Ghost row
`define NUM_GHOSTS       5
`define GHOST_Y          150
`define GHOST_X0         150
`define GHOST_X1         550
`define GHOST_X2         960
`define GHOST_X3         1180
`define GHOST_X4         1650
`define GHOST_HALF_W     20
`define GHOST_HALF_H     25
`define GHOST_R2         400    // Rounded top, radius 20 squared

// Colours
`define COL_FLAKE        24'hFF_FF_FF
`define COL_PACMAN       24'hFF_FF_00
`define COL_GHOST0       24'hFF_B0_FF  // Pink
`define COL_GHOST1       24'hFF_00_00  // Red
`define COL_GHOST2       24'h00_80_FF  // Blue
`define COL_GHOST3       24'h00_FF_00  // Green
`define COL_GHOST4       24'h80_00_FF  // Purple
`define COL_EYE          24'hFF_FF_FF
`define COL_BLACK        24'h00_00_00

`endif

// File: snow_overlay_golden.txt
# frame x y rgb : frame = vblank falls since reset, x y = pixel on the raster
# rgb = expected composed colour, 24-bit hex, red in the top byte
0 100 600 000000
0 935 250 FFFF00
0 970 240 FFFF00
0 985 250 000000
0 960 285 000000
0 150 160 FFB0FF
0 550 150 FF0000
0 940 150 0080FF
0 1180 155 00FF00
0 1650 165 8000FF
0 562 140 FFFFFF
0 1171 143 000000
0 165 173 000000
0 150 174 FFB0FF
0 132 130 000000
0 160 90 FFFFFF
0 805 450 FFFFFF
0 804 454 FFFFFF
0 803 455 000000
5 480 290 FFFFFF
10 960 610 FFFFFF
22 1760 1078 FFFFFF
23 1897 0 FFFFFF
23 1760 1078 000000
30 160 150 FFFFFF
30 150 160 FFB0FF

// File: snow_overlay_props.sv
/*
 Concurrent properties on the overlay output register.
 Bound into snow_overlay_top; checks reset values, the one-cycle
 sync delay and the hold on stalled cycles.
*/
`timescale 1ns/1ps
`default_nettype none

module snow_overlay_props
    import video_stream_pkg::*;
(
    input wire logic  clk_i,
    input wire logic  rst_i,
    input wire logic  cen_i,
    input wire sync_t sync_i,
    input wire rgb_t  rgb_out_i,    // DUT rgb_o
    input wire sync_t sync_out_i    // DUT sync_o
);

    // Output register cleared by the reset edge
    reset_clears: assert property (@(posedge clk_i)
        rst_i |=> (rgb_out_i == '0) && (sync_out_i == '0))
        else $error("Outputs not cleared after reset");

    sync_delay: assert property (@(posedge clk_i)
        !rst_i && cen_i |=> sync_out_i == $past(sync_i))
        else $error("sync_o is not sync_i delayed by one enabled cycle");

    // Stalled cycle, nothing moves
    stall_hold: assert property (@(posedge clk_i)
        !rst_i && !cen_i |=> $stable(rgb_out_i) && $stable(sync_out_i))
        else $error("Output changed on a cycle with cen_i low");

endmodule

bind snow_overlay_top snow_overlay_props u_props (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .cen_i      (cen_i),
    .sync_i     (sync_i),
    .rgb_out_i  (rgb_o),
    .sync_out_i (sync_o)
);

`default_nettype wire

// File: snow_overlay_top.sv
/*
 Snow overlay stage, top level.
 Tracks the raster, draws snow and characters and composes them over
 black. One enabled cycle from input pixel to rgb_o and sync_o.
*/
`timescale 1ns/1ps
`default_nettype none

module snow_overlay_top
    import video_stream_pkg::*;
    import overlay_pkg::*;
(
    input  wire logic   clk_i,
    input  wire logic   rst_i,
    input  wire logic   cen_i,     // Pixel enable, low stalls everything
    input  wire blank_t blank_i,
    input  wire sync_t  sync_i,
    output rgb_t        rgb_o,
    output sync_t       sync_o
);

    raster_pos_t pos;
    logic        frame_start;
    layer_px_t   flake_l;
    layer_px_t   char_l;

    raster_position u_raster (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .cen_i         (cen_i),
        .blank_i       (blank_i),
        .pos_o         (pos),
        .frame_start_o (frame_start)
    );

    snowflake_field u_snow (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .cen_i         (cen_i),
        .frame_start_i (frame_start),
        .pos_i         (pos),
        .layer_o       (flake_l)
    );

    character_sprites u_chars (
        .pos_i   (pos),
        .layer_o (char_l)
    );

    layer_compositor u_comp (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .cen_i   (cen_i),
        .sync_i  (sync_i),
        .char_i  (char_l),
        .flake_i (flake_l),
        .rgb_o   (rgb_o),
        .sync_o  (sync_o)
    );

endmodule

`default_nettype wire

// File: snowflake_field.sv
/*
 Snowflake field.
 Holds twelve flakes, moves them down once per frame and wraps them to
 the top with a shifted x. Draws a small star per flake around its centre
 and reports a hit for the current raster position, combinationally.
*/
`timescale 1ns/1ps
`default_nettype none

module snowflake_field
    import video_stream_pkg::*;
    import overlay_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        rst_i,
    input  wire logic        cen_i,
    input  wire logic        frame_start_i,
    input  wire raster_pos_t pos_i,
    output layer_px_t        layer_o
);

`include "snow_overlay_consts.svh"

    flake_t                  flakes  [`NUM_FLAKES];
    flake_t                  flake_nx[`NUM_FLAKES];  // Positions for the next frame
    logic [`NUM_FLAKES-1:0]  hit;                    // One bit per flake

    // Star shape: centre, two bars and the 45 degree diagonals
    function automatic logic flake_hit(input raster_pos_t p, input flake_t f);
        coord_t dx;
        coord_t dy;
        dx = (p.x >= f.x) ? p.x - f.x : f.x - p.x;
        dy = (p.y >= f.y) ? p.y - f.y : f.y - p.y;
        flake_hit = (dx <= `FLAKE_HALF) && (dy <= `FLAKE_HALF) &&
                    ((dx < 2 && dy < 2) ||                     // Centre
                     (dy < 2 && dx < `FLAKE_HALF) ||           // Horizontal bar
                     (dx < 2 && dy < `FLAKE_HALF) ||           // Vertical bar
                     (dx == dy && dx < `FLAKE_HALF));          // Diagonals
    endfunction

    // Fall by speed, wrap to the top with a new column
    always_comb begin
        logic [11:0] y_sum;
        logic [11:0] x_sum;
        for (int j = 0; j < `NUM_FLAKES; j++) begin
            y_sum       = {1'b0, flakes[j].y} + 12'(flakes[j].speed);
            x_sum       = {1'b0, flakes[j].x} + 12'(`FLAKE_WRAP_STEP);
            flake_nx[j] = flakes[j];
            if (y_sum >= 12'(`SCREEN_H)) begin
                flake_nx[j].y = '0;
                flake_nx[j].x = (x_sum >= 12'(`SCREEN_W)) ?
                                coord_t'(x_sum - 12'(`SCREEN_W)) : coord_t'(x_sum);
            end else begin
                flake_nx[j].y = coord_t'(y_sum);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int j = 0; j < `NUM_FLAKES; j++) begin  // Spread over the screen
                flakes[j].x     <= coord_t'((j * `FLAKE_X_SPACING) % `SCREEN_W);
                flakes[j].y     <= coord_t'((j * `FLAKE_Y_SPACING) % `SCREEN_H);
                flakes[j].speed <= 4'((j % 8) + 1);
            end
        end else if (cen_i && frame_start_i) begin
            flakes <= flake_nx;                          // Once per frame
        end
    end

    for (genvar j = 0; j < `NUM_FLAKES; j++) begin : g_draw
        assign hit[j] = flake_hit(pos_i, flakes[j]);
    end

    // All flakes share one colour, so the top flake is just any hit
    always_comb begin
        layer_o.hit = |hit;
        layer_o.rgb = layer_o.hit ? rgb_t'(`COL_FLAKE) : rgb_t'(`COL_BLACK);
    end

endmodule

`default_nettype wire

// File: tb_snow_overlay.sv
/*
 Testbench for the snow overlay stage.
 Checks the reset values, then the one-cycle sync delay under random
 stalls. After that it walks the raster to every pixel listed in the
 golden file and compares the composed colour. Ends with one summary
 line and the verdict.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_snow_overlay
    import video_stream_pkg::*;
();

`include "snow_overlay_consts.svh"

    localparam int CYCLE_BUDGET = 2_000_000;  // Whole-run limit in clock cycles
    localparam int SYNC_TRIALS  = 64;

    logic        clk_i;
    logic        rst_i;
    logic        cen_i;
    blank_t      blank_i;
    sync_t       sync_i;
    rgb_t        rgb_o;
    sync_t       sync_o;

    logic [31:0] rng;            // Xorshift state
    int          frames_done;    // Vblank falls since the last reset
    logic        need_reset;     // Raster state unknown, start over
    int          checks;
    int          rgb_errors;
    int          sync_errors;
    int          other_errors;

    snow_overlay_top uut (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .cen_i   (cen_i),
        .blank_i (blank_i),
        .sync_i  (sync_i),
        .rgb_o   (rgb_o),
        .sync_o  (sync_o)
    );

    always #10 clk_i = ~clk_i;   // 20 ns period

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // Inputs change on the falling edge, outputs are read there too
    task automatic tick();
        @(negedge clk_i);
    endtask

    task automatic set_blank(input logic v, input logic h);
        blank_i.vblank = v;
        blank_i.hblank = h;
    endtask

    // One enabled cycle, sometimes preceded by a short cen_i gap
    task automatic enabled_step();
        int gaps;
        int g;
        rng  = xorshift32(rng);
        gaps = (rng[4:2] == 3'd0) ? int'(rng[6:5]) + 1 : 0;
        for (g = 0; g < gaps; g++) begin
            cen_i = 1'b0;
            tick();
        end
        cen_i = 1'b1;
        tick();
    endtask

    task automatic apply_reset();
        int n;
        rst_i = 1'b1;
        cen_i = 1'b1;
        set_blank(1'b0, 1'b1);
        for (n = 0; n < 3; n++) begin
            tick();
        end
        rst_i       = 1'b0;
        frames_done = 0;
        need_reset  = 1'b0;
    endtask

    task automatic check_rgb(input string name, input rgb_t exp, input rgb_t act);
        checks++;
        if (act !== exp) begin
            rgb_errors++;
            $display("** Error [%s] expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_sync(input string name, input sync_t exp, input sync_t act);
        checks++;
        if (act !== exp) begin
            sync_errors++;
            $display("** Error [%s] expected %b, actual %b", name, exp, act);
        end
    endtask

    // Random sync words echo one enabled cycle later, stalls hold everything
    task automatic sync_echo();
        sync_t exp;
        sync_t drv;
        rgb_t  held;
        logic  en;
        int    i;
        exp = '0;
        for (i = 0; i < SYNC_TRIALS; i++) begin
            rng    = xorshift32(rng);
            drv    = sync_t'(rng[2:0]);
            en     = (rng[9:8] != 2'b00);     // About one stall in four
            held   = rgb_o;
            sync_i = drv;
            cen_i  = en;
            set_blank(1'b0, rng[12]);         // Random line breaks around flake 0
            tick();
            if (en) exp = drv;
            check_sync($sformatf("sync echo %0d", i), exp, sync_o);
            if (!en) check_rgb($sformatf("stall hold %0d", i), held, rgb_o);
        end
        sync_i = '0;
        cen_i  = 1'b1;
    endtask

    // Reach pixel (x, y) in frame f through blank edges only
    task automatic visit(input int f, input int x, input int y, output rgb_t got);
        int lines;
        int i;
        if (need_reset || f <= frames_done) apply_reset();
        lines = y;
        if (f == 0) begin
            set_blank(1'b0, 1'b1);           // First hblank rise after reset, y = 1
            enabled_step();
            lines = y - 1;
        end
        for (i = frames_done; i < f; i++) begin
            set_blank(1'b1, 1'b1);
            enabled_step();
            set_blank(1'b0, 1'b1);           // Vblank falls, flakes move, y = 0
            enabled_step();
        end
        frames_done = (f > frames_done) ? f : frames_done;
        for (i = 0; i < lines; i++) begin    // Short lines, one active cycle each
            set_blank(1'b0, 1'b0);
            enabled_step();
            set_blank(1'b0, 1'b1);
            enabled_step();
        end
        set_blank(1'b0, 1'b0);
        for (i = 0; i < x + 2; i++) begin    // x cleared, counted, then registered
            enabled_step();
        end
        got = rgb_o;
        set_blank(1'b0, 1'b1);               // Back into hblank
        enabled_step();
    endtask

    task automatic run_golden();
        int          fd;
        int          n;
        int          rec;
        int          f;
        int          x;
        int          y;
        logic [23:0] col;
        rgb_t        got;
        string       line;
        fd  = $fopen("snow_overlay_golden.txt", "r");
        rec = 0;
        if (fd == 0) begin
            $display("The golden file snow_overlay_golden.txt could not be opened");
            other_errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() >= 2 && line[0] != "#") begin   // Skip notes and blanks
                    n = $sscanf(line, "%d %d %d %h", f, x, y, col);
                    rec++;
                    if (n != 4) begin
                        $display("Golden record %0d is malformed: %s", rec, line);
                        other_errors++;
                    end else if (x >= `SCREEN_W || y >= `SCREEN_H || (f == 0 && y == 0)) begin
                        $display("Golden record %0d names a pixel the driver cannot reach", rec);
                        other_errors++;
                    end else begin
                        visit(f, x, y, got);
                        check_rgb($sformatf("frame %0d pixel (%0d,%0d)", f, x, y),
                                  rgb_t'(col), got);
                    end
                end
            end
            $fclose(fd);
            if (rec == 0) begin
                $display("The golden file holds no records");
                other_errors++;
            end
        end
    endtask

    // Hard stop if the run never reaches its end
    initial begin : watchdog
        int n;
        for (n = 0; n < CYCLE_BUDGET; n++) begin
            @(posedge clk_i);
        end
        $display("Timeout: the test did not finish within %0d clock cycles", CYCLE_BUDGET);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        clk_i        = 1'b0;
        rst_i        = 1'b1;
        cen_i        = 1'b1;
        sync_i       = '1;                   // Nonzero in reset, must not reach sync_o
        set_blank(1'b0, 1'b1);
        rng          = 32'h0b41ba07;
        frames_done  = 0;
        need_reset   = 1'b1;
        checks       = 0;
        rgb_errors   = 0;
        sync_errors  = 0;
        other_errors = 0;

        apply_reset();
        check_rgb("reset rgb_o", '0, rgb_o);
        check_sync("reset sync_o", '0, sync_o);
        sync_echo();

        need_reset = 1'b1;                   // Raster moved during the echo test
        run_golden();

        $display("Checks %0d, rgb errors %0d, sync errors %0d, other errors %0d",
                 checks, rgb_errors, sync_errors, other_errors);
        if (rgb_errors + sync_errors + other_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: video_stream_pkg.sv
/*
 Types of the incoming and outgoing pixel stream.
 Colour, sync and blank bundles plus the raster position.
 Imported by every RTL module of the overlay stage.
*/
`default_nettype none

package video_stream_pkg;

    // Pixel colour, red in the top byte
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    // HDMI style sync bundle, {de, vsync, hsync}
    typedef struct packed {
        logic de;
        logic vsync;
        logic hsync;
    } sync_t;

    // Blanking flags, {vblank, hblank}
    typedef struct packed {
        logic vblank;
        logic hblank;
    } blank_t;

    typedef logic [10:0] coord_t;  // Up to 2047, covers 1920

    // Current pixel on the raster
    typedef struct packed {
        coord_t x;
        coord_t y;
    } raster_pos_t;

endpackage

`default_nettype wire
